// File: common/rcc_params.svh
`ifndef RCC_PARAMS_SVH
`define RCC_PARAMS_SVH

// ----------------------------------------
// register word layout
// ----------------------------------------
`define RCC_DATA_W          32
// rsr remove-flags bit
`define RCC_RMVF_BIT        16
// lowest flag bit, holds oblrstf
`define RCC_FLAG_LSB        17
// hole in the flag field, reads zero
`define RCC_FLAG_RSVD_BIT   18
// csr bits
`define RCC_LSION_BIT       0
`define RCC_LSIRDY_BIT      1

// ----------------------------------------
// reset cause indices into rst_src
// ----------------------------------------
`define RCC_SRC_N           14
`define RCC_SRC_OBL         0
`define RCC_SRC_D1          1
`define RCC_SRC_D2          2
`define RCC_SRC_BOR         3
`define RCC_SRC_PIN         4
`define RCC_SRC_POR         5
`define RCC_SRC_SFT1        6
`define RCC_SRC_SFT2        7
`define RCC_SRC_IWDG1       8
`define RCC_SRC_IWDG2       9
`define RCC_SRC_WWDG1       10
`define RCC_SRC_WWDG2       11
`define RCC_SRC_LPWR1       12
`define RCC_SRC_LPWR2       13

// lsi ready resync depth
`define RCC_LSI_SYNC_N      2

`endif

// File: common/rcc_pkg.sv
`include "rcc_params.svh"

package rcc_pkg;

    // ----------------------------------------
    // register word, two decodes
    // ----------------------------------------
    // rsr view (per core reset status)
    //   31..19  cause flags, index i at 18+i
    //   18      reserved
    //   17      oblrstf
    //   16      rmvf
    //   15..0   reserved
    //
    // csr view (lsi control/status)
    //   31..2   reserved
    //   1       lsirdy
    //   0       lsion
    //
    // both views are one 32 bit word so the
    // same wdata bus feeds every register
    typedef union packed {
        // status register decode
        struct packed {
            // sticky cause flags, bit 18 unused
            logic [`RCC_DATA_W-1:`RCC_FLAG_LSB]      flags;
            // remove flags, holds flags clear while set
            logic                                   rmvf;
            // low half unused
            logic [`RCC_RMVF_BIT-1:0]               rsvd;
        } rsr;
        // control register decode
        struct packed {
            // upper bits unused
            logic [`RCC_DATA_W-1:`RCC_LSIRDY_BIT+1]  rsvd;
            // resynced oscillator ready
            logic                                   lsirdy;
            // oscillator enable
            logic                                   lsion;
        } csr;
    } rcc_word_u;

endpackage

// File: hdl/rcc_reset_flags.sv
`timescale 1ns/100ps
`include "rcc_params.svh"

module rcc_reset_flags (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wren,
    input  rcc_pkg::rcc_word_u      wdata,
    input  logic [`RCC_SRC_N-1:0]   rst_src,
    output rcc_pkg::rcc_word_u      rsr
);

    // only porrstf comes out of reset set
    localparam logic [`RCC_SRC_N-1:0] flag_rst_val =
        `RCC_SRC_N'(1) << `RCC_SRC_POR;

    // registered remove-flags bit
    logic                                   rmvf;
    // sticky flags in cause index order
    logic [`RCC_SRC_N-1:0]                  flag;
    logic [`RCC_SRC_N-1:0]                  flag_nxt;
    // flags placed at their map positions
    logic [`RCC_DATA_W-1:`RCC_FLAG_LSB]     flag_field;

    // ----------------------------------------
    // rmvf
    // ----------------------------------------
    // follows the written bit, set or clear
    always_ff @(posedge clk) begin
        if (rst) begin
            rmvf <= 1'b0;
        end else if (wren) begin
            rmvf <= wdata.rsr.rmvf;
        end
    end

    // ----------------------------------------
    // flag next state
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < `RCC_SRC_N; i++) begin
            if (i == `RCC_SRC_POR) begin
                // power-on set wins over rmvf
                if (rst_src[i]) begin
                    flag_nxt[i] = 1'b1;
                end else if (rmvf) begin
                    flag_nxt[i] = 1'b0;
                end else begin
                    flag_nxt[i] = flag[i];
                end
            end else begin
                // rmvf wins, flag stays clear while set
                if (rmvf) begin
                    flag_nxt[i] = 1'b0;
                end else if (rst_src[i]) begin
                    flag_nxt[i] = 1'b1;
                end else begin
                    flag_nxt[i] = flag[i];
                end
            end
        end
    end

    // flag state
    always_ff @(posedge clk) begin
        if (rst) begin
            flag <= flag_rst_val;
        end else begin
            flag <= flag_nxt;
        end
    end

    // ----------------------------------------
    // read word
    // ----------------------------------------
    // obl sits at 17, the rest at 18+i
    always_comb begin
        flag_field = '0;
        for (int i = 0; i < `RCC_SRC_N; i++) begin
            if (i == `RCC_SRC_OBL) begin
                flag_field[`RCC_FLAG_LSB] = flag[i];
            end else begin
                flag_field[`RCC_FLAG_RSVD_BIT + i] = flag[i];
            end
        end
    end

    // reserved bits stay zero
    always_comb begin
        rsr           = '0;
        rsr.rsr.flags = flag_field;
        rsr.rsr.rmvf  = rmvf;
    end

endmodule

// File: hdl/rcc_lsi_ctrl.sv
`timescale 1ns/100ps
`include "rcc_params.svh"

module rcc_lsi_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                wren,
    input  rcc_pkg::rcc_word_u  wdata,
    input  logic                lsi_rdy,
    output rcc_pkg::rcc_word_u  csr
);

    // oscillator enable
    logic                           lsion;
    // ready resync chain, msb is the output stage
    logic [`RCC_LSI_SYNC_N-1:0]     rdy_sync;

    // ----------------------------------------
    // lsion
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            lsion <= 1'b0;
        end else if (wren) begin
            lsion <= wdata.csr.lsion;
        end
    end

    // ----------------------------------------
    // lsirdy resync
    // ----------------------------------------
    // lsi_rdy is async, shift in at the lsb
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_sync <= '0;
        end else begin
            rdy_sync <= (rdy_sync << 1) | `RCC_LSI_SYNC_N'(lsi_rdy);
        end
    end

    // read word, upper bits zero
    always_comb begin
        csr            = '0;
        csr.csr.lsion  = lsion;
        csr.csr.lsirdy = rdy_sync[`RCC_LSI_SYNC_N-1];
    end

endmodule

// File: hdl/rcc_vdd_regs.sv
`timescale 1ns/100ps
`include "rcc_params.svh"

module rcc_vdd_regs (
    input  logic                    clk,
    input  logic                    rst,
    // shared write data for all three registers
    input  rcc_pkg::rcc_word_u      wdata,
    // one cycle write strobes
    input  logic                    c1_rsr_wren,
    input  logic                    c2_rsr_wren,
    input  logic                    csr_wren,
    // reset cause pulses, common to both cores
    input  logic [`RCC_SRC_N-1:0]   rst_src,
    // async oscillator ready level
    input  logic                    lsi_rdy,
    // read words
    output rcc_pkg::rcc_word_u      c1_rsr,
    output rcc_pkg::rcc_word_u      c2_rsr,
    output rcc_pkg::rcc_word_u      csr
);

    // ----------------------------------------
    // core 1 reset status
    // ----------------------------------------
    rcc_reset_flags u_c1_rsr (
        .clk        (clk),
        .rst        (rst),
        .wren       (c1_rsr_wren),
        .wdata      (wdata),
        .rst_src    (rst_src),
        .rsr        (c1_rsr)
    );

    // ----------------------------------------
    // core 2 reset status
    // ----------------------------------------
    // same causes as core 1, own rmvf
    rcc_reset_flags u_c2_rsr (
        .clk        (clk),
        .rst        (rst),
        .wren       (c2_rsr_wren),
        .wdata      (wdata),
        .rst_src    (rst_src),
        .rsr        (c2_rsr)
    );

    // ----------------------------------------
    // lsi control/status
    // ----------------------------------------
    // lsion storage and lsirdy resync
    rcc_lsi_ctrl u_lsi_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wren       (csr_wren),
        .wdata      (wdata),
        .lsi_rdy    (lsi_rdy),
        .csr        (csr)
    );

endmodule

// File: tb/tb_rcc_vdd_regs.sv
`timescale 1ns/100ps
`include "rcc_params.svh"

module tb_rcc_vdd_regs;

    localparam int n_tests     = 5;
    localparam int wdog_cycles = n_tests * 200 + 50;

    logic                   clk;
    logic                   rst;
    rcc_pkg::rcc_word_u     wdata;
    logic                   c1_rsr_wren;
    logic                   c2_rsr_wren;
    logic                   csr_wren;
    logic [`RCC_SRC_N-1:0]  rst_src;
    logic                   lsi_rdy;
    rcc_pkg::rcc_word_u     c1_rsr;
    rcc_pkg::rcc_word_u     c2_rsr;
    rcc_pkg::rcc_word_u     csr;

    integer                 seed;
    logic [31:0]            rnd;
    int                     errors;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     err_mark;
    // expected status words
    logic [31:0]            exp_c1;
    logic [31:0]            exp_c2;
    logic [31:0]            por_mask;

    rcc_vdd_regs i_rcc_vdd_regs (
        .clk         (clk),
        .rst         (rst),
        .wdata       (wdata),
        .c1_rsr_wren (c1_rsr_wren),
        .c2_rsr_wren (c2_rsr_wren),
        .csr_wren    (csr_wren),
        .rst_src     (rst_src),
        .lsi_rdy     (lsi_rdy),
        .c1_rsr      (c1_rsr),
        .c2_rsr      (c2_rsr),
        .csr         (csr)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // lsirdy is lsi_rdy delayed by the sync depth
    // ----------------------------------------
    property p_lsirdy_delay;
        @(posedge clk) disable iff (rst)
            csr.csr.lsirdy == $past(lsi_rdy, `RCC_LSI_SYNC_N);
    endproperty

    a_lsirdy_delay: assert property (p_lsirdy_delay) else begin
        $display("FAIL %0t: lsirdy does not follow lsi_rdy after %0d cycles",
            $time, `RCC_LSI_SYNC_N);
        errors++;
    end

    // obl at bit 17 and every other cause at 18+i
    function automatic logic [31:0] cause_mask(input logic [`RCC_SRC_N-1:0] src);
        logic [31:0] m;
        m = 32'h0;
        for (int i = 0; i < `RCC_SRC_N; i++) begin
            if (src[i]) begin
                if (i == `RCC_SRC_OBL) begin
                    m[17] = 1'b1;
                end else begin
                    m[18 + i] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    // inputs change 2 ns after the edge where outputs are stable
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        if (errors == err_before) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    // single cycle pulse on the cause vector
    task automatic pulse_causes(input logic [`RCC_SRC_N-1:0] src);
        rst_src = src;
        next_cycle();
        rst_src = '0;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic check_reset_values();
        check_word("c1_rsr after reset", c1_rsr, por_mask);
        check_word("c2_rsr after reset", c2_rsr, por_mask);
        check_word("csr after reset", csr, 32'h0);
    endtask

    task automatic run_cause_pulses();
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            exp_c1 = exp_c1 | cause_mask(rnd[`RCC_SRC_N-1:0]);
            exp_c2 = exp_c2 | cause_mask(rnd[`RCC_SRC_N-1:0]);
            pulse_causes(rnd[`RCC_SRC_N-1:0]);
            next_cycle();
            // sticky after the pulse ends
            check_word("c1_rsr after pulse", c1_rsr, exp_c1);
            check_word("c2_rsr after pulse", c2_rsr, exp_c2);
        end
    endtask

    task automatic run_rmvf_clear();
        logic [`RCC_SRC_N-1:0] src;
        // set rmvf on core 1 only
        wdata = 32'h0001_0000;
        c1_rsr_wren = 1'b1;
        next_cycle();
        c1_rsr_wren = 1'b0;
        wdata = 32'h0;
        next_cycle();
        check_word("c1_rsr after rmvf set", c1_rsr, 32'h0001_0000);
        check_word("c2_rsr after c1 rmvf set", c2_rsr, exp_c2);
        // non por causes stay clear on core 1
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            src = rnd[`RCC_SRC_N-1:0];
            src[`RCC_SRC_POR] = 1'b0;
            exp_c2 = exp_c2 | cause_mask(src);
            pulse_causes(src);
            next_cycle();
            check_word("c1_rsr held by rmvf", c1_rsr, 32'h0001_0000);
            check_word("c2_rsr during c1 rmvf", c2_rsr, exp_c2);
        end
        // por beats rmvf for one cycle and then rmvf clears it
        exp_c2 = exp_c2 | por_mask;
        pulse_causes(`RCC_SRC_N'(1) << `RCC_SRC_POR);
        check_word("c1_rsr por over rmvf", c1_rsr, 32'h0001_0000 | por_mask);
        next_cycle();
        check_word("c1_rsr por cleared by rmvf", c1_rsr, 32'h0001_0000);
        // release rmvf and set flags again
        wdata = 32'h0;
        c1_rsr_wren = 1'b1;
        next_cycle();
        c1_rsr_wren = 1'b0;
        next_cycle();
        rnd = $random(seed);
        src = rnd[`RCC_SRC_N-1:0] | (`RCC_SRC_N'(1) << `RCC_SRC_SFT1);
        exp_c1 = cause_mask(src);
        exp_c2 = exp_c2 | cause_mask(src);
        pulse_causes(src);
        next_cycle();
        check_word("c1_rsr after rmvf release", c1_rsr, exp_c1);
        check_word("c2_rsr after rmvf release", c2_rsr, exp_c2);
    endtask

    task automatic run_lsion_writes();
        wdata = 32'h0000_0001;
        csr_wren = 1'b1;
        next_cycle();
        csr_wren = 1'b0;
        check_word("csr after lsion write", csr, 32'h0000_0001);
        // data alone without the strobe
        wdata = 32'hffff_fffe;
        next_cycle();
        next_cycle();
        check_word("csr with data but no strobe", csr, 32'h0000_0001);
        // status writes leave the control word alone
        c1_rsr_wren = 1'b1;
        c2_rsr_wren = 1'b1;
        next_cycle();
        c1_rsr_wren = 1'b0;
        c2_rsr_wren = 1'b0;
        next_cycle();
        check_word("csr after status writes", csr, 32'h0000_0001);
        check_word("c1_rsr after status write", c1_rsr, 32'h0001_0000);
        check_word("c2_rsr after status write", c2_rsr, 32'h0001_0000);
        // and the reverse, rmvf bit low in the written word
        wdata = 32'hfffe_fffe;
        csr_wren = 1'b1;
        next_cycle();
        csr_wren = 1'b0;
        next_cycle();
        check_word("csr after lsion clear", csr, 32'h0);
        check_word("c1_rsr after csr write", c1_rsr, 32'h0001_0000);
        check_word("c2_rsr after csr write", c2_rsr, 32'h0001_0000);
        wdata = 32'h0;
    endtask

    task automatic run_lsirdy_sync();
        // random level changes for the concurrent check
        for (int k = 0; k < 40; k++) begin
            rnd = $random(seed);
            lsi_rdy = rnd[0];
            next_cycle();
        end
        lsi_rdy = 1'b1;
        repeat (`RCC_LSI_SYNC_N) next_cycle();
        check_word("lsirdy after rise", {31'h0, csr.csr.lsirdy}, 32'h1);
        lsi_rdy = 1'b0;
        repeat (`RCC_LSI_SYNC_N - 1) next_cycle();
        check_word("lsirdy before fall", {31'h0, csr.csr.lsirdy}, 32'h1);
        next_cycle();
        check_word("lsirdy after fall", {31'h0, csr.csr.lsirdy}, 32'h0);
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        repeat (wdog_cycles) @(posedge clk);
        $display("watchdog timeout, the tests did not complete in %0d cycles", wdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    // main sequence
    initial begin
        seed = 38;
        errors = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        rst = 1'b1;
        wdata = 32'h0;
        c1_rsr_wren = 1'b0;
        c2_rsr_wren = 1'b0;
        csr_wren = 1'b0;
        rst_src = '0;
        lsi_rdy = 1'b0;
        por_mask = cause_mask(`RCC_SRC_N'(1) << `RCC_SRC_POR);
        exp_c1 = por_mask;
        exp_c2 = por_mask;
        repeat (10) next_cycle();
        rst = 1'b0;
        next_cycle();

        err_mark = errors;
        check_reset_values();
        close_test("reset values", err_mark);
        err_mark = errors;
        run_cause_pulses();
        close_test("cause pulses", err_mark);
        err_mark = errors;
        run_rmvf_clear();
        close_test("rmvf clear", err_mark);
        err_mark = errors;
        run_lsion_writes();
        close_test("lsion writes", err_mark);
        err_mark = errors;
        run_lsirdy_sync();
        close_test("lsirdy sync", err_mark);

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
            pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+common
common/rcc_pkg.sv
hdl/rcc_reset_flags.sv
hdl/rcc_lsi_ctrl.sv
hdl/rcc_vdd_regs.sv
tb/tb_rcc_vdd_regs.sv

// File: Makefile
# Verilator build and run for the rcc vdd register block
#
# override on the command line, for example
#   make test LOG=run.log SEED_ARGS=+verilator+seed+7

VERILATOR ?= verilator
TOP       ?= tb_rcc_vdd_regs
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+38
VFLAGS    ?= --binary --assert

SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  build  compile only"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG SEED_ARGS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: build
	./$(SIM_BIN) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
